// ==== hdl/mem_op_pkg.sv ====
`default_nettype none

// ======================================================================
// Memory operation codes seen on the core's internal bus
// ======================================================================

package mem_op_pkg;

  // Width of the req_op field
  localparam int MEM_OP_W = 4;

  // Loads first, then stores, numbered in this order on the bus
  localparam logic [MEM_OP_W-1:0] OP_LB  = 4'd0; // Signed byte
  localparam logic [MEM_OP_W-1:0] OP_LH  = 4'd1; // Signed halfword
  localparam logic [MEM_OP_W-1:0] OP_LW  = 4'd2; // Full word
  localparam logic [MEM_OP_W-1:0] OP_LBU = 4'd3; // Unsigned byte
  localparam logic [MEM_OP_W-1:0] OP_LHU = 4'd4; // Unsigned halfword
  localparam logic [MEM_OP_W-1:0] OP_SB  = 4'd5; // Byte store
  localparam logic [MEM_OP_W-1:0] OP_SH  = 4'd6; // Halfword store
  localparam logic [MEM_OP_W-1:0] OP_SW  = 4'd7; // Word store

  // True for the three store operations
  // Anything else, including unused codes, is handled as a load
  function automatic logic is_store(input logic [MEM_OP_W-1:0] op);
    logic store;
    store = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    return store;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/data_bus_pkg.sv ====
`default_nettype none

// ======================================================================
// External data bus and data RAM dimensions
// ======================================================================

package data_bus_pkg;

  // Data and address width of the bus
  localparam int XLEN = 32;

  // One strobe bit per byte lane
  localparam int STRB_W = XLEN / 8;

  // RAM depth in words, 256 words cover byte addresses 0 to 1023
  localparam int RAM_WORDS = 256;

  // Word index width, taken from daddr just above the byte offset
  localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

  // Cycles from the RAM seeing dvalid to it raising dready
  localparam int RAM_WAIT_STATES = 2;

  // Wait counter width, one extra value so a single wait state still fits
  localparam int WAIT_CNT_W = $clog2(RAM_WAIT_STATES + 1);

endpackage

`default_nettype wire

// ==== hdl/store_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Turns a core store into an aligned bus word plus byte strobes
// The narrow data is copied into every lane so the strobes alone pick
// the bytes that land in memory
module store_formatter (
  input  logic [mem_op_pkg::MEM_OP_W-1:0]   op,
  input  logic [1:0]                        byte_offset,
  input  logic [data_bus_pkg::XLEN-1:0]     store_data,
  output logic [data_bus_pkg::XLEN-1:0]     wdata,
  output logic [data_bus_pkg::STRB_W-1:0]   wstb
);

  import mem_op_pkg::*;
  import data_bus_pkg::*;

  // Single strobe bit at lane 0, shifted up for byte stores
  localparam logic [STRB_W-1:0] LANE0_STRB = {{(STRB_W - 1){1'b0}}, 1'b1};

  always_comb begin
    wdata = {XLEN{1'b0}};                          // Loads put nothing on the bus
    wstb  = {STRB_W{1'b0}};
    if (is_store(op)) begin
      case (op)
        OP_SB: begin
          wdata = {4{store_data[7:0]}};             // Byte copied to all four lanes
          wstb  = LANE0_STRB << byte_offset;        // One lane enabled
        end
        OP_SH: begin
          wdata = {2{store_data[15:0]}};            // Halfword in both halves
          // Offset bit 1 picks the upper or lower strobe pair
          if (byte_offset[1]) begin
            wstb = 4'b1100;
          end else begin
            wstb = 4'b0011;
          end
        end
        default: begin
          // Only OP_SW is left here, the low offset bits are ignored
          wdata = store_data;
          wstb  = {STRB_W{1'b1}};
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/load_extractor.sv ====
`timescale 1ns/1ps
`default_nettype none

// Picks the addressed lane out of a bus read word and widens it to XLEN
// Signed loads copy the lane's top bit, unsigned loads fill with zero
module load_extractor (
  input  logic [mem_op_pkg::MEM_OP_W-1:0]   op,
  input  logic [1:0]                        byte_offset,
  input  logic [data_bus_pkg::XLEN-1:0]     rdata,
  output logic [data_bus_pkg::XLEN-1:0]     load_data
);

  import mem_op_pkg::*;
  import data_bus_pkg::*;

  logic [7:0]  byte_lane;   // Byte at the addressed offset
  logic [15:0] half_lane;   // Halfword at the addressed half

  // ======================================================================
  // Lane selection
  // ======================================================================

  always_comb begin
    // The offset counts bytes, so scale it by eight for the bit position
    byte_lane = rdata[{byte_offset, 3'b000} +: 8];
    // Bit 0 of the offset plays no part in a halfword access
    if (byte_offset[1]) begin
      half_lane = rdata[31:16];
    end else begin
      half_lane = rdata[15:0];
    end
  end

  // ======================================================================
  // Extension
  // ======================================================================

  always_comb begin
    case (op)
      OP_LB: begin
        load_data = {{(XLEN - 8){byte_lane[7]}}, byte_lane};    // Sign from bit 7
      end
      OP_LBU: begin
        load_data = {{(XLEN - 8){1'b0}}, byte_lane};
      end
      OP_LH: begin
        load_data = {{(XLEN - 16){half_lane[15]}}, half_lane};  // Sign from bit 15
      end
      OP_LHU: begin
        load_data = {{(XLEN - 16){1'b0}}, half_lane};
      end
      default: begin
        // OP_LW, and stores whose result nobody reads
        load_data = rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// Takes one request at a time from the core's internal bus and runs it
// as a single access on the external data bus
module load_store_unit (
  input  logic                                clock,
  input  logic                                reset,
  // Core side
  input  logic                                req_valid,
  input  logic [data_bus_pkg::XLEN-1:0]       req_addr,
  input  logic [mem_op_pkg::MEM_OP_W-1:0]     req_op,
  input  logic [data_bus_pkg::XLEN-1:0]       req_data,
  output logic                                ack_valid,
  output logic [data_bus_pkg::XLEN-1:0]       ack_data,
  // External data bus
  output logic                                dvalid,
  output logic [data_bus_pkg::XLEN-1:0]       daddr,
  output logic [data_bus_pkg::XLEN-1:0]       dwdata,
  output logic [data_bus_pkg::STRB_W-1:0]     dwstb,
  output logic                                dwrite,
  input  logic [data_bus_pkg::XLEN-1:0]       drdata,
  input  logic                                dready
);

  import mem_op_pkg::*;
  import data_bus_pkg::*;

  typedef enum logic {
    ST_WAIT_REQ,    // Idle until the core presents a request
    ST_WAIT_RSP     // Bus access in flight, waiting on dready
  } state_t;

  state_t state;

  logic [XLEN-1:0]   fmt_wdata;  // Store word ready for the bus
  logic [STRB_W-1:0] fmt_wstb;   // Strobes matching fmt_wdata
  logic [XLEN-1:0]   ext_data;   // Load result taken from drdata
  logic              take_req;   // Request accepted at this edge
  logic              rsp_done;   // Bus answered at this edge

  // A request seen together with the ack pulse is the old one still held
  assign take_req = (state == ST_WAIT_REQ) && req_valid && !ack_valid;
  assign rsp_done = (state == ST_WAIT_RSP) && dready;

  // Store fields come straight from the request
  store_formatter u_store_formatter (
    .op          (req_op),
    .byte_offset (req_addr[1:0]),
    .store_data  (req_data),
    .wdata       (fmt_wdata),
    .wstb        (fmt_wstb)
  );

  // The core holds req_op through the response, the offset comes from daddr
  load_extractor u_load_extractor (
    .op          (req_op),
    .byte_offset (daddr[1:0]),
    .rdata       (drdata),
    .load_data   (ext_data)
  );

  // ======================================================================
  // Control
  // ======================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ST_WAIT_REQ;
      ack_valid <= 1'b0;
      dvalid    <= 1'b0;
      dwrite    <= 1'b0;
      dwstb     <= {STRB_W{1'b0}};
    end else begin
      ack_valid <= 1'b0;                    // Pulse lasts a single cycle
      case (state)
        ST_WAIT_REQ: begin
          if (take_req) begin
            state  <= ST_WAIT_RSP;
            dvalid <= 1'b1;                 // Address and write fields set alongside
            dwrite <= is_store(req_op);
            dwstb  <= fmt_wstb;
          end
        end
        default: begin
          if (dready) begin
            state     <= ST_WAIT_REQ;
            ack_valid <= 1'b1;
            dvalid    <= 1'b0;              // Bus drops back to idle
            dwrite    <= 1'b0;
            dwstb     <= {STRB_W{1'b0}};
          end
        end
      endcase
    end
  end

  // ======================================================================
  // Payload
  // ======================================================================

  always_ff @(posedge clock) begin
    if (take_req) begin
      daddr  <= req_addr;                   // Full address, the RAM drops the offset
      dwdata <= fmt_wdata;
    end
    if (rsp_done) begin
      ack_data <= ext_data;                 // Valid with the ack pulse
    end
  end

  // Bus fields hold steady until the RAM answers
  a_bus_stable: assert property (@(posedge clock) disable iff (reset)
    (dvalid && !dready) |=> ($stable(daddr) && $stable(dwrite) && $stable(dwstb)));

  // Strobes only go out with a write
  a_strobe_write: assert property (@(posedge clock) disable iff (reset)
    (dwstb != {STRB_W{1'b0}}) |-> dwrite);

  // One ack per request, never a held level
  a_ack_pulse: assert property (@(posedge clock) disable iff (reset)
    ack_valid |=> !ack_valid);

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// Word RAM behind the external data bus, with byte strobes and a fixed
// number of wait states before each dready pulse
module data_ram (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              dvalid,
  input  logic [data_bus_pkg::XLEN-1:0]     daddr,
  input  logic [data_bus_pkg::XLEN-1:0]     dwdata,
  input  logic [data_bus_pkg::STRB_W-1:0]   dwstb,
  input  logic                              dwrite,
  output logic [data_bus_pkg::XLEN-1:0]     drdata,
  output logic                              dready
);

  import data_bus_pkg::*;

  logic [XLEN-1:0]       mem [RAM_WORDS];
  logic [WAIT_CNT_W-1:0] wait_cnt;   // Cycles of the current access so far
  logic [RAM_ADDR_W-1:0] word_idx;   // Upper address bits wrap past the top
  logic                  finish;     // Last wait state, answer at this edge

  assign word_idx = daddr[RAM_ADDR_W+1:2];

  // Once dready is up the access is over, so it must not count again
  assign finish = dvalid && !dready && (wait_cnt == WAIT_CNT_W'(RAM_WAIT_STATES - 1));

  // ======================================================================
  // Wait counter and strobed write
  // ======================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= {XLEN{1'b0}};
      end
      wait_cnt <= {WAIT_CNT_W{1'b0}};
      dready   <= 1'b0;
    end else begin
      dready <= finish;                     // One cycle pulse
      if (finish) begin
        wait_cnt <= {WAIT_CNT_W{1'b0}};
        if (dwrite) begin
          // Each strobe bit enables one byte lane
          for (int b = 0; b < STRB_W; b++) begin
            if (dwstb[b]) begin
              mem[word_idx][8*b +: 8] <= dwdata[8*b +: 8];
            end
          end
        end
      end else if (dvalid && !dready) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // Read sees the word from before a write in the same access
  always_ff @(posedge clock) begin
    if (finish) begin
      drdata <= mem[word_idx];
    end
  end

  // The RAM never answers without an access in progress
  a_ready_needs_valid: assert property (@(posedge clock) disable iff (reset)
    dready |-> dvalid);

endmodule

`default_nettype wire

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

// Data-memory path, load/store unit in front of the data RAM
// Only the core-side request and ack ports leave this level
module mem_subsystem (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              req_valid,
  input  logic [data_bus_pkg::XLEN-1:0]     req_addr,
  input  logic [mem_op_pkg::MEM_OP_W-1:0]   req_op,
  input  logic [data_bus_pkg::XLEN-1:0]     req_data,
  output logic                              ack_valid,
  output logic [data_bus_pkg::XLEN-1:0]     ack_data
);

  import data_bus_pkg::*;

  // External data bus between the two blocks
  logic              dvalid;
  logic [XLEN-1:0]   daddr;
  logic [XLEN-1:0]   dwdata;
  logic [STRB_W-1:0] dwstb;
  logic              dwrite;
  logic [XLEN-1:0]   drdata;
  logic              dready;

  load_store_unit u_load_store_unit (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_op    (req_op),
    .req_data  (req_data),
    .ack_valid (ack_valid),
    .ack_data  (ack_data),
    .dvalid    (dvalid),
    .daddr     (daddr),
    .dwdata    (dwdata),
    .dwstb     (dwstb),
    .dwrite    (dwrite),
    .drdata    (drdata),
    .dready    (dready)
  );

  data_ram u_data_ram (
    .clock  (clock),
    .reset  (reset),
    .dvalid (dvalid),
    .daddr  (daddr),
    .dwdata (dwdata),
    .dwstb  (dwstb),
    .dwrite (dwrite),
    .drdata (drdata),
    .dready (dready)
  );

endmodule

`default_nettype wire

// ==== tb/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

  import mem_op_pkg::*;
  import data_bus_pkg::*;

  // About 85 requests take roughly five cycles each and fit well inside this limit
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int SHADOW_BYTES   = RAM_WORDS * 4;  // Byte image of the whole RAM

  logic                clock;
  logic                reset;
  logic                req_valid;
  logic [XLEN-1:0]     req_addr;
  logic [MEM_OP_W-1:0] req_op;
  logic [XLEN-1:0]     req_data;
  logic                ack_valid;
  logic [XLEN-1:0]     ack_data;

  logic [7:0] shadow [SHADOW_BYTES];  // Expected RAM contents with one entry per byte
  int         errors;
  int         checks;
  int         cycles;
  int         ack_count;                // Every ack pulse seen on the core side
  int         req_count;                // Every request the bench presented
  integer     seed;

  mem_subsystem uut (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_op    (req_op),
    .req_data  (req_data),
    .ack_valid (ack_valid),
    .ack_data  (ack_data)
  );

  always #4 clock = ~clock;           // 8 ns period

  // ======================================================================
  // Timeout and ack counting
  // ======================================================================

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  always @(posedge clock) begin
    if (!reset && ack_valid) begin
      ack_count++;                    // Flop output read before this edge updates it
    end
  end

  // ======================================================================
  // Shadow memory model
  // ======================================================================

  // Byte stores hit one lane, halfwords a pair picked by offset bit 1, words all four
  function automatic void update_shadow(input logic [MEM_OP_W-1:0] op,
                                        input logic [XLEN-1:0] addr,
                                        input logic [XLEN-1:0] data);
    logic [9:0] base;
    base = addr[9:0];                 // Addresses wrap above 1023
    case (op)
      OP_SB: begin
        shadow[base] = data[7:0];
      end
      OP_SH: begin
        base[0] = 1'b0;
        shadow[base]         = data[7:0];
        shadow[base | 10'd1] = data[15:8];
      end
      OP_SW: begin
        base[1:0] = 2'b00;
        for (int i = 0; i < 4; i++) begin
          shadow[base | 10'(i)] = data[8*i +: 8];  // Little endian lanes
        end
      end
      default: begin
      end
    endcase
  endfunction

  // Value a load should return as built from the shadow bytes
  function automatic logic [XLEN-1:0] expected_load(input logic [MEM_OP_W-1:0] op,
                                                    input logic [XLEN-1:0] addr);
    logic [9:0]  base;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    base = addr[9:0];
    b = shadow[base];
    base[0] = 1'b0;                   // Halfword ignores offset bit 0
    h = {shadow[base | 10'd1], shadow[base]};
    base[1] = 1'b0;
    w = {shadow[base | 10'd3], shadow[base | 10'd2], shadow[base | 10'd1], shadow[base]};
    case (op)
      OP_LB:   return {{24{b[7]}}, b};
      OP_LBU:  return {24'h0, b};
      OP_LH:   return {{16{h[15]}}, h};
      OP_LHU:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // ======================================================================
  // Request helpers
  // ======================================================================

  task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Presents one request on the rising edge and holds it until the ack pulse
  task automatic run_access(input logic [MEM_OP_W-1:0] op, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] data, output logic [XLEN-1:0] result);
    @(posedge clock);
    req_valid <= 1'b1;
    req_addr  <= addr;
    req_op    <= op;
    req_data  <= data;
    req_count++;
    @(negedge clock);
    while (!ack_valid) begin
      @(negedge clock);               // Outputs are settled away from the edge
    end
    result = ack_data;
    update_shadow(op, addr, data);    // Loads leave the model unchanged
  endtask

  task automatic store_value(input logic [MEM_OP_W-1:0] op, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] data);
    logic [XLEN-1:0] unused;
    run_access(op, addr, data, unused);
  endtask

  task automatic load_and_check(input string name, input logic [MEM_OP_W-1:0] op,
                                input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] got;
    logic [XLEN-1:0] expected;
    expected = expected_load(op, addr);
    run_access(op, addr, 32'h0, got);
    check_value(name, expected, got);
  endtask

  task automatic release_request();
    @(posedge clock);
    req_valid <= 1'b0;
  endtask

  // ======================================================================
  // Directed tests
  // ======================================================================

  task automatic check_after_reset();
    logic [XLEN-1:0] r;
    @(negedge clock);
    checks++;
    assert (ack_valid === 1'b0) else begin
      errors++;
      $display("Mismatch in check_after_reset: expected ack_valid 0, actual %b", ack_valid);
    end
    r = $random(seed);
    load_and_check("check_after_reset", OP_LW, 32'h000);
    load_and_check("check_after_reset", OP_LW, 32'h3fc);
    load_and_check("check_after_reset", OP_LW, {22'h0, r[9:0]});  // Any address reads zero
  endtask

  task automatic word_round_trip();
    logic [XLEN-1:0] addrs [5];
    addrs = '{32'h000, 32'h004, 32'h123, 32'h3fc, 32'h40c};  // 0x40c wraps onto 0x00c
    for (int i = 0; i < 5; i++) begin
      store_value(OP_SW, addrs[i], $random(seed));
    end
    for (int i = 0; i < 5; i++) begin
      load_and_check("word_round_trip", OP_LW, addrs[i]);
    end
    load_and_check("word_round_trip", OP_LW, 32'h00c);
  endtask

  task automatic byte_lane_writes();
    logic [7:0]      bytes [4];
    logic [XLEN-1:0] data;
    bytes = '{8'h85, 8'h7a, 8'hc3, 8'h0f};  // Two of them negative as bytes
    store_value(OP_SW, 32'h040, 32'h11223344);
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      data[7:0] = bytes[i];           // Upper bits must not reach memory
      store_value(OP_SB, 32'h040 + i, data);
      load_and_check("byte_lane_writes", OP_LW, 32'h040);
    end
    for (int i = 0; i < 4; i++) begin
      load_and_check("byte_lane_writes", OP_LB, 32'h040 + i);
      load_and_check("byte_lane_writes", OP_LBU, 32'h040 + i);
    end
  endtask

  task automatic halfword_lane_writes();
    store_value(OP_SW, 32'h080, $random(seed));
    store_value(OP_SH, 32'h080, 32'h5a5a8a5c);
    load_and_check("halfword_lane_writes", OP_LW, 32'h080);
    store_value(OP_SH, 32'h082, 32'h1234f00d);
    load_and_check("halfword_lane_writes", OP_LW, 32'h080);
    for (int i = 0; i < 4; i++) begin
      load_and_check("halfword_lane_writes", OP_LH, 32'h080 + i);
      load_and_check("halfword_lane_writes", OP_LHU, 32'h080 + i);
    end
  endtask

  task automatic random_traffic();
    logic [XLEN-1:0]     r;
    logic [MEM_OP_W-1:0] op;
    logic [XLEN-1:0]     addr;
    logic [XLEN-1:0]     data;
    logic [XLEN-1:0]     got;
    logic [XLEN-1:0]     expected;
    for (int n = 0; n < 40; n++) begin
      r    = $random(seed);
      op   = {1'b0, r[2:0]};
      addr = {22'h0, 4'h8, r[13:8]};  // 64 byte window so loads meet earlier stores
      data = $random(seed);
      expected = expected_load(op, addr);
      run_access(op, addr, data, got);  // Next request follows right after the ack
      if (op != OP_SB && op != OP_SH && op != OP_SW) begin
        check_value("random_traffic", expected, got);
      end
    end
    release_request();
    @(negedge clock);
    checks++;
    assert (ack_count == req_count) else begin
      errors++;
      $display("Mismatch in random_traffic: expected %0d ack pulses, actual %0d",
               req_count, ack_count);
    end
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    seed      = 32'h00c62899;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    ack_count = 0;
    req_count = 0;
    clock     = 1'b0;
    reset     <= 1'b1;
    req_valid <= 1'b0;
    req_addr  <= '0;
    req_op    <= OP_LW;
    req_data  <= '0;
    for (int i = 0; i < SHADOW_BYTES; i++) begin
      shadow[i] = 8'h00;              // RAM clears to zero on reset
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    check_after_reset();
    word_round_trip();
    byte_lane_writes();
    halfword_lane_writes();
    random_traffic();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/mem_op_pkg.sv
hdl/data_bus_pkg.sv
hdl/store_formatter.sv
hdl/load_extractor.sv
hdl/load_store_unit.sv
hdl/data_ram.sv
hdl/mem_subsystem.sv
tb/mem_subsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f build.f --top-module mem_subsystem_tb \
       -Mdir obj_dir \
  && ./obj_dir/Vmem_subsystem_tb | tee /dev/stderr | grep "Result: PASSED" > /dev/null \
  || { echo "Simulation did not pass"; exit 1; }
